// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - hdl/axil_pkg.sv
  - hdl/exec_pkg.sv
  - hdl/skid_buffer.sv
  - hdl/int_to_float.sv
  - hdl/exec_unit.sv
  - hdl/exec_csr.sv
  - hdl/exec_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/exec_tb.sv

// ==== hdl/axil_pkg.sv ====
/*
  AXI4-Lite channel types and the register map of the execution unit.
  Registers are 32 bits wide on a byte address; there is no burst support.
*/
package axil_pkg;

	// ====================
	// Bus geometry
	// ====================

	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	// Response codes as defined by the AXI spec
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ====================
	// Channel payloads
	// ====================

	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [AXIL_DATA_W-1:0] data;
		logic [AXIL_STRB_W-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [AXIL_DATA_W-1:0] data;
		logic [1:0]             resp;
	} axil_r_t;

	// ====================
	// Register map
	// ====================

	// Bit 0 enables issue into the pipeline
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL       = 8'h00;
	// Two halves of the value returned for undefined opcodes
	localparam logic [AXIL_ADDR_W-1:0] REG_DEFAULT_LO = 8'h04;
	localparam logic [AXIL_ADDR_W-1:0] REG_DEFAULT_HI = 8'h08;
	// Read-only counters, both wrap at 32 bits
	localparam logic [AXIL_ADDR_W-1:0] REG_OP_COUNT   = 8'h0C;
	localparam logic [AXIL_ADDR_W-1:0] REG_BAD_COUNT  = 8'h10;

endpackage

// ==== hdl/exec_csr.sv ====
/*
  AXI4-Lite register block for the execution unit.
  One write and one read may be pending at a time; counters are read-only.
*/
`timescale 1ns/10ps

module exec_csr import axil_pkg::*, exec_pkg::*; #(
	parameter logic [XLEN-1:0] DEFAULT_RESET = 64'h7ff8_0000_0000_0000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            aw_valid,
	output logic            aw_ready,
	input  axil_aw_t        aw,
	input  logic            w_valid,
	output logic            w_ready,
	input  axil_w_t         w,
	output logic            b_valid,
	input  logic            b_ready,
	output axil_b_t         b,
	input  logic            ar_valid,
	output logic            ar_ready,
	input  axil_ar_t        ar,
	output logic            r_valid,
	input  logic            r_ready,
	output axil_r_t         r,
	input  logic            done_pulse,
	input  logic            bad_pulse,
	output logic            enable,
	output logic [XLEN-1:0] default_value
);

	logic                   wr_fire;
	logic                   wr_ok;
	logic                   rd_fire;
	logic                   rd_ok;
	logic [AXIL_DATA_W-1:0] rd_data;
	logic [31:0]            op_count;
	logic [31:0]            bad_count;

	// Byte-wise update of one 32-bit register
	function automatic logic [AXIL_DATA_W-1:0] merge(input logic [AXIL_DATA_W-1:0] old,
			input axil_w_t wr);
		logic [AXIL_DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < AXIL_STRB_W; i++) begin
			if (wr.strb[i]) begin
				res[8*i +: 8] = wr.data[8*i +: 8];
			end
		end
		return res;
	endfunction

	// ====================
	// Write path
	// ====================

	// AW and W are taken together and only once the last B has gone
	assign wr_fire  = aw_valid && w_valid && !b_valid;
	assign aw_ready = wr_fire;
	assign w_ready  = wr_fire;
	assign wr_ok    = (aw.addr == REG_CTRL) || (aw.addr == REG_DEFAULT_LO) ||
		(aw.addr == REG_DEFAULT_HI);

	always_ff @(posedge clk) begin
		if (rst) begin
			enable        <= 1'b0;
			default_value <= DEFAULT_RESET;
		end else if (wr_fire) begin
			case (aw.addr)
				REG_CTRL: begin
					if (w.strb[0]) begin
						enable <= w.data[0];
					end
				end
				REG_DEFAULT_LO: default_value[31:0] <= merge(default_value[31:0], w);
				REG_DEFAULT_HI: default_value[XLEN-1:32] <= merge(default_value[XLEN-1:32], w);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			b_valid <= 1'b0;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
		end else if (b_ready) begin
			b_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			b.resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ====================
	// Read path
	// ====================

	assign ar_ready = ar_valid && !r_valid;
	assign rd_fire  = ar_valid && ar_ready;

	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (ar.addr)
			REG_CTRL:       rd_data = {{(AXIL_DATA_W-1){1'b0}}, enable};
			REG_DEFAULT_LO: rd_data = default_value[31:0];
			REG_DEFAULT_HI: rd_data = default_value[XLEN-1:32];
			REG_OP_COUNT:   rd_data = op_count;
			REG_BAD_COUNT:  rd_data = bad_count;
			default:        rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid <= 1'b0;
		end else if (rd_fire) begin
			r_valid <= 1'b1;
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r.data <= rd_data;
			r.resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Counters wrap silently
	always_ff @(posedge clk) begin
		if (rst) begin
			op_count  <= '0;
			bad_count <= '0;
		end else begin
			if (done_pulse) op_count <= op_count + 32'd1;
			if (bad_pulse) bad_count <= bad_count + 32'd1;
		end
	end

endmodule

// ==== hdl/exec_pkg.sv ====
/*
  Opcodes and request/response payloads of the execution unit.
  Float ops assume IEEE 754 binary64 operands held in 64-bit integer words.
*/
package exec_pkg;

	// ====================
	// Widths
	// ====================

	localparam int XLEN  = 64;
	localparam int TAG_W = 8;

	// Binary64 field layout, sign sits at bit XLEN-1
	localparam int EXP_W    = 11;
	localparam int MANT_W   = 52;
	localparam int EXP_BIAS = 1023;

	// ====================
	// Opcodes
	// ====================

	// Codes 16 to 31 are undefined and return the default register value
	typedef enum logic [4:0] {
		// Three-input integer and logic ops
		OP_ADD3   = 5'd0,
		OP_SUB3   = 5'd1,
		OP_ANDC   = 5'd2,
		OP_ORC    = 5'd3,
		OP_XORC   = 5'd4,
		OP_MAJ    = 5'd5,
		OP_CMOVZ  = 5'd6,
		OP_CMPLT  = 5'd7,
		// Double-precision sign manipulation
		OP_FABS   = 5'd8,
		OP_FNEG   = 5'd9,
		OP_FSGNJ  = 5'd10,
		OP_FSGNJN = 5'd11,
		OP_FSGNJX = 5'd12,
		// Classification, result is 1 or 0
		OP_ISNAN  = 5'd13,
		OP_FINITE = 5'd14,
		// Signed integer to double, truncating
		OP_ITOF   = 5'd15
	} exec_op_e;

	// How the third operand joins the first result of ANDC/ORC/XORC
	// Code 3 is not a member and yields zero
	typedef enum logic [1:0] {
		COMB_AND = 2'd0,
		COMB_OR  = 2'd1,
		COMB_XOR = 2'd2
	} combine_e;

	// ====================
	// Payloads
	// ====================

	typedef struct packed {
		exec_op_e         op;
		combine_e         comb;
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  b;
		logic [XLEN-1:0]  c;
		logic [TAG_W-1:0] tag;
	} exec_req_t;

	typedef struct packed {
		logic [XLEN-1:0]  value;
		logic [TAG_W-1:0] tag;
		// Set when the opcode was undefined
		logic             bad;
	} exec_rsp_t;

endpackage

// ==== hdl/exec_top.sv ====
/*
  Execution unit top level, 5 cycles from op to result without back-pressure.
  The op port stays closed until software sets the enable bit.
*/
`timescale 1ns/10ps

module exec_top import axil_pkg::*, exec_pkg::*; #(
	parameter logic [XLEN-1:0] DEFAULT_RESET = 64'h7ff8_0000_0000_0000
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      op_valid,
	output logic      op_ready,
	input  exec_req_t op,
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output exec_rsp_t rsp,
	input  logic      aw_valid,
	output logic      aw_ready,
	input  axil_aw_t  aw,
	input  logic      w_valid,
	output logic      w_ready,
	input  axil_w_t   w,
	output logic      b_valid,
	input  logic      b_ready,
	output axil_b_t   b,
	input  logic      ar_valid,
	output logic      ar_ready,
	input  axil_ar_t  ar,
	output logic      r_valid,
	input  logic      r_ready,
	output axil_r_t   r
);

	logic            enable;
	logic [XLEN-1:0] default_value;
	logic            done_pulse;
	logic            bad_pulse;
	logic            buf_in_valid;
	logic            buf_in_ready;
	logic            req_valid;
	logic            req_ready;
	exec_req_t       req;
	logic            res_valid;
	logic            res_ready;
	exec_rsp_t       res;

	// Enable closes the port itself, not only the pipeline behind the buffer
	assign op_ready     = buf_in_ready && enable;
	assign buf_in_valid = op_valid && enable;

	skid_buffer #(.payload_t(exec_req_t)) in_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (buf_in_valid),
		.in_ready  (buf_in_ready),
		.in_data   (op),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req)
	);

	exec_unit unit (
		.clk           (clk),
		.rst           (rst),
		.s_valid       (req_valid),
		.s_ready       (req_ready),
		.s_req         (req),
		.m_valid       (res_valid),
		.m_ready       (res_ready),
		.m_rsp         (res),
		.enable        (enable),
		.default_value (default_value),
		.done_pulse    (done_pulse),
		.bad_pulse     (bad_pulse)
	);

	skid_buffer #(.payload_t(exec_rsp_t)) out_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (res_valid),
		.in_ready  (res_ready),
		.in_data   (res),
		.out_valid (rsp_valid),
		.out_ready (rsp_ready),
		.out_data  (rsp)
	);

	exec_csr #(.DEFAULT_RESET(DEFAULT_RESET)) csr (
		.clk           (clk),
		.rst           (rst),
		.aw_valid      (aw_valid),
		.aw_ready      (aw_ready),
		.aw            (aw),
		.w_valid       (w_valid),
		.w_ready       (w_ready),
		.w             (w),
		.b_valid       (b_valid),
		.b_ready       (b_ready),
		.b             (b),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.ar            (ar),
		.r_valid       (r_valid),
		.r_ready       (r_ready),
		.r             (r),
		.done_pulse    (done_pulse),
		.bad_pulse     (bad_pulse),
		.enable        (enable),
		.default_value (default_value)
	);

endmodule

// ==== hdl/exec_unit.sv ====
/*
  Three-stage execution pipeline with a fixed latency of 3 cycles.
  All stages advance together, a stall at the output freezes every stage.
*/
`timescale 1ns/10ps

module exec_unit import exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            s_valid,
	output logic            s_ready,
	input  exec_req_t       s_req,
	output logic            m_valid,
	input  logic            m_ready,
	output exec_rsp_t       m_rsp,
	input  logic            enable,
	input  logic [XLEN-1:0] default_value,
	output logic            done_pulse,
	output logic            bad_pulse
);

	logic            advance;
	logic            in_fire;
	logic            v1, v2, v3;
	logic            itof1, itof2, itof3;
	exec_rsp_t       rsp1, rsp2, rsp3;
	exec_rsp_t       fast;
	logic            fast_itof;
	logic [XLEN-1:0] conv;
	logic            a_exp_ones;
	logic            a_mant_nz;

	// Pipeline moves when the last stage is empty or being taken
	assign advance = !v3 || m_ready;
	// Disabling only blocks new issue, ops in flight still drain
	assign s_ready = advance && enable;
	assign in_fire = s_valid && s_ready;

	function automatic logic [XLEN-1:0] combine(input logic [XLEN-1:0] x,
			input logic [XLEN-1:0] c, input combine_e mode);
		case (mode)
			COMB_AND: return x & c;
			COMB_OR:  return x | c;
			COMB_XOR: return x ^ c;
			default:  return '0;
		endcase
	endfunction

	assign a_exp_ones = &s_req.a[XLEN-2 -: EXP_W];
	assign a_mant_nz  = |s_req.a[MANT_W-1:0];

	// ====================
	// Stage 1 decode
	// ====================

	always_comb begin
		fast.value = '0;
		fast.tag   = s_req.tag;
		fast.bad   = 1'b0;
		fast_itof  = 1'b0;
		case (s_req.op)
			OP_ADD3:   fast.value = s_req.a + s_req.b + s_req.c;
			OP_SUB3:   fast.value = s_req.a - s_req.b - s_req.c;
			OP_ANDC:   fast.value = combine(s_req.a & s_req.b, s_req.c, s_req.comb);
			OP_ORC:    fast.value = combine(s_req.a | s_req.b, s_req.c, s_req.comb);
			OP_XORC:   fast.value = combine(s_req.a ^ s_req.b, s_req.c, s_req.comb);
			OP_MAJ:    fast.value = (s_req.a & s_req.b) | (s_req.a & s_req.c) |
				(s_req.b & s_req.c);
			OP_CMOVZ:  fast.value = (s_req.a == '0) ? s_req.b : s_req.c;
			OP_CMPLT:  fast.value = {{(XLEN-1){1'b0}}, $signed(s_req.a) < $signed(s_req.b)};
			// Sign ops touch only the top bit, NaN payloads pass unchanged
			OP_FABS:   fast.value = {1'b0, s_req.a[XLEN-2:0]};
			OP_FNEG:   fast.value = {~s_req.a[XLEN-1], s_req.a[XLEN-2:0]};
			OP_FSGNJ:  fast.value = {s_req.a[XLEN-1], s_req.b[XLEN-2:0]};
			OP_FSGNJN: fast.value = {~s_req.a[XLEN-1], s_req.b[XLEN-2:0]};
			OP_FSGNJX: fast.value = {s_req.a[XLEN-1] ^ s_req.b[XLEN-1], s_req.b[XLEN-2:0]};
			OP_ISNAN:  fast.value = {{(XLEN-1){1'b0}}, a_exp_ones && a_mant_nz};
			OP_FINITE: fast.value = {{(XLEN-1){1'b0}}, !a_exp_ones};
			// Value comes from the converter in stage 3
			OP_ITOF:   fast_itof = 1'b1;
			default: begin
				fast.value = default_value;
				fast.bad   = 1'b1;
			end
		endcase
	end

	// ====================
	// Stage registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else if (advance) begin
			v1 <= in_fire;
			v2 <= v1;
			v3 <= v2;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			rsp1  <= fast;
			itof1 <= fast_itof;
			rsp2  <= rsp1;
			itof2 <= itof1;
			rsp3  <= rsp2;
			itof3 <= itof2;
		end
	end

	// Converter shares the advance signal so its stage 3 lines up with ours
	int_to_float i2f (
		.clk     (clk),
		.rst     (rst),
		.advance (advance),
		.value   (s_req.a),
		.result  (conv)
	);

	// Stage 3 picks the converter output for ITOF
	always_comb begin
		m_rsp = rsp3;
		if (itof3) begin
			m_rsp.value = conv;
		end
	end

	assign m_valid    = v3;
	assign done_pulse = v3 && m_ready;
	assign bad_pulse  = done_pulse && rsp3.bad;

endmodule

// ==== hdl/int_to_float.sv ====
/*
  Signed 64-bit integer to binary64, rounding toward zero, three stages.
  All stages move only on advance, and there is no valid tracking here.
*/
`timescale 1ns/10ps

module int_to_float import exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            advance,
	input  logic [XLEN-1:0] value,
	output logic [XLEN-1:0] result
);

	localparam int LZ_W = $clog2(XLEN);
	// Exponent of a value whose top set bit is bit XLEN-1
	localparam logic [EXP_W-1:0] EXP_TOP = EXP_W'(EXP_BIAS + XLEN - 1);

	// Stage 1 holds sign and magnitude
	logic            s1_sign;
	logic [XLEN-1:0] s1_mag;
	// Stage 2 holds the normalized magnitude
	logic            s2_sign;
	logic            s2_zero;
	logic [XLEN-1:0] s2_norm;
	logic [LZ_W-1:0] s2_lz;
	logic [LZ_W-1:0] lz;
	logic [EXP_W-1:0] exp_biased;

	// Last set bit seen from the bottom is the leading one
	function automatic logic [LZ_W-1:0] count_lz(input logic [XLEN-1:0] x);
		logic [LZ_W-1:0] n;
		n = '0;
		for (int i = 0; i < XLEN; i++) begin
			if (x[i]) begin
				n = LZ_W'(XLEN - 1 - i);
			end
		end
		return n;
	endfunction

	assign lz = count_lz(s1_mag);

	// ====================
	// Stages 1 and 2
	// ====================

	// Negating the most negative integer gives 2^63 as unsigned, which is exact
	always_ff @(posedge clk) begin
		if (advance) begin
			s1_sign <= value[XLEN-1];
			s1_mag  <= value[XLEN-1] ? -value : value;
			s2_sign <= s1_sign;
			s2_zero <= (s1_mag == '0);
			s2_lz   <= lz;
			s2_norm <= s1_mag << lz;
		end
	end

	// ====================
	// Stage 3
	// ====================

	assign exp_biased = EXP_TOP - EXP_W'(s2_lz);

	// Leading one is implicit, bits below the mantissa are simply dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
		end else if (advance) begin
			if (s2_zero) begin
				result <= '0;
			end else begin
				result <= {s2_sign, exp_biased, s2_norm[XLEN-2 -: MANT_W]};
			end
		end
	end

endmodule

// ==== hdl/skid_buffer.sv ====
/*
  Two-entry valid/ready stage, output fully registered.
  in_ready comes from local state only, so it never waits on out_ready.
*/
`timescale 1ns/10ps

module skid_buffer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     main_valid;
	logic     spare_valid;
	payload_t main_data;
	payload_t spare_data;
	logic     main_load;
	logic     spare_load;
	logic     in_fire;

	// New input is refused only while the spare entry holds an item
	assign in_ready  = !spare_valid;
	assign in_fire   = in_valid && in_ready;
	assign out_valid = main_valid;
	assign out_data  = main_data;

	// Main entry may take a new item when empty or being drained this cycle
	assign main_load  = !main_valid || out_ready;
	// Output stalled while an item arrives, so park it in the spare entry
	assign spare_load = !main_load && in_fire;

	always_ff @(posedge clk) begin
		if (rst) begin
			main_valid  <= 1'b0;
			spare_valid <= 1'b0;
		end else if (main_load) begin
			// A parked item always goes out before anything newer
			main_valid  <= spare_valid || in_valid;
			spare_valid <= 1'b0;
		end else if (in_fire) begin
			spare_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (main_load) begin
			main_data <= spare_valid ? spare_data : in_data;
		end
		if (spare_load) begin
			spare_data <= in_data;
		end
	end

endmodule

// ==== project.f ====
hdl/axil_pkg.sv
hdl/exec_pkg.sv
hdl/skid_buffer.sv
hdl/int_to_float.sv
hdl/exec_unit.sv
hdl/exec_csr.sv
hdl/exec_top.sv
tests/tb_clock.sv
tests/exec_tb.sv

// ==== tests/exec_tb.sv ====
/*
  Testbench for exec_top that checks results in issue order against a model.
  Inputs change on the falling edge and handshakes are sampled on the rising edge.
*/
`timescale 1ns/10ps

module exec_tb import axil_pkg::*, exec_pkg::*; ();

	localparam logic [XLEN-1:0] DEFAULT_RST = 64'h7ff8_0000_0000_0bad;
	localparam logic [XLEN-1:0] SIGN_BIT    = 64'h8000_0000_0000_0000;
	localparam int              WAIT_LIMIT  = 1000;

	logic      clk;
	logic      rst;
	logic      op_valid;
	logic      op_ready;
	exec_req_t op;
	logic      rsp_valid;
	logic      rsp_ready = 1'b1;
	exec_rsp_t rsp;
	logic      aw_valid;
	logic      aw_ready;
	axil_aw_t  aw;
	logic      w_valid;
	logic      w_ready;
	axil_w_t   w;
	logic      b_valid;
	logic      b_ready;
	axil_b_t   b;
	logic      ar_valid;
	logic      ar_ready;
	axil_ar_t  ar;
	logic      r_valid;
	logic      r_ready;
	axil_r_t   r;

	// Scoreboard state with expectations queued in issue order
	exec_rsp_t        expect_q[$];
	int               errors = 0;
	int               checks = 0;
	int               rsp_seen = 0;
	int               ops_done = 0;
	int               bad_done = 0;
	logic [TAG_W-1:0] next_tag = '0;
	logic [XLEN-1:0]  dflt_value = DEFAULT_RST;
	logic [31:0]      ctrl_value = 32'd0;
	bit               ready_pat[1024];
	int               pat_idx = 0;
	logic             ready_random = 1'b0;

	tb_clock clock_gen (
		.clk (clk),
		.rst (rst)
	);

	exec_top #(.DEFAULT_RESET(DEFAULT_RST)) exec_top_i (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op_ready  (op_ready),
		.op        (op),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.aw_valid  (aw_valid),
		.aw_ready  (aw_ready),
		.aw        (aw),
		.w_valid   (w_valid),
		.w_ready   (w_ready),
		.w         (w),
		.b_valid   (b_valid),
		.b_ready   (b_ready),
		.b         (b),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.ar        (ar),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.r         (r)
	);

	// ====================
	// Reference model
	// ====================

	// Truncating conversion that shifts the magnitude so its top one lands on bit 52
	function automatic logic [XLEN-1:0] to_double_trunc(input logic [XLEN-1:0] x);
		logic            sign;
		logic [XLEN-1:0] mag;
		logic [XLEN-1:0] frac;
		int              msb;
		sign = x[XLEN-1];
		mag  = sign ? (~x + 64'd1) : x;
		if (mag == '0) return '0;
		msb = XLEN - 1;
		while (!mag[msb]) msb--;
		if (msb > MANT_W) frac = mag >> (msb - MANT_W);
		else frac = mag << (MANT_W - msb);
		return {sign, EXP_W'(EXP_BIAS + msb), frac[MANT_W-1:0]};
	endfunction

	function automatic exec_rsp_t exec_model(input exec_req_t req, input logic [XLEN-1:0] dflt);
		exec_rsp_t       res;
		logic [XLEN-1:0] ab;
		logic [EXP_W-1:0] ea;
		logic            a_lt_b;
		res.tag   = req.tag;
		res.bad   = 1'b0;
		res.value = '0;
		ea = req.a[XLEN-2 -: EXP_W];
		case (req.op)
			OP_ADD3: res.value = req.a + req.b + req.c;
			OP_SUB3: res.value = req.a - (req.b + req.c);
			OP_ANDC, OP_ORC, OP_XORC: begin
				if (req.op == OP_ANDC) ab = req.a & req.b;
				else if (req.op == OP_ORC) ab = req.a | req.b;
				else ab = req.a ^ req.b;
				case (req.comb)
					2'd0: res.value = ab & req.c;
					2'd1: res.value = ab | req.c;
					2'd2: res.value = ab ^ req.c;
					default: res.value = '0;
				endcase
			end
			OP_MAJ: res.value = (req.a & (req.b | req.c)) | (req.b & req.c);
			OP_CMOVZ: res.value = (req.a == '0) ? req.b : req.c;
			OP_CMPLT: begin
				// Differing signs decide alone and equal signs compare as unsigned
				if (req.a[XLEN-1] != req.b[XLEN-1]) a_lt_b = req.a[XLEN-1];
				else a_lt_b = req.a < req.b;
				res.value = {63'd0, a_lt_b};
			end
			OP_FABS: res.value = req.a & ~SIGN_BIT;
			OP_FNEG: res.value = req.a ^ SIGN_BIT;
			OP_FSGNJ: res.value = (req.b & ~SIGN_BIT) | (req.a & SIGN_BIT);
			OP_FSGNJN: res.value = (req.b & ~SIGN_BIT) | (~req.a & SIGN_BIT);
			OP_FSGNJX: res.value = req.b ^ (req.a & SIGN_BIT);
			OP_ISNAN: res.value = {63'd0, (ea == '1) && (req.a[MANT_W-1:0] != '0)};
			OP_FINITE: res.value = {63'd0, ea != '1};
			OP_ITOF: res.value = to_double_trunc(req.a);
			default: begin
				res.value = dflt;
				res.bad   = 1'b1;
			end
		endcase
		return res;
	endfunction

	// ====================
	// Stimulus helpers
	// ====================

	function automatic logic [XLEN-1:0] random_word();
		return {$urandom, $urandom};
	endfunction

	// Float corner cases and integer edges up to 15 and random words above
	function automatic logic [XLEN-1:0] special_operand(input int k);
		case (k)
			0: return 64'h0000_0000_0000_0000;
			1: return SIGN_BIT;
			2: return 64'h7ff0_0000_0000_0000;
			3: return 64'hfff0_0000_0000_0000;
			4: return 64'h7ff8_0000_0000_0000;
			5: return 64'hfff0_0000_0000_0001;
			6: return 64'h7fff_ffff_ffff_ffff;
			7: return 64'h0000_0000_0000_0001;
			8: return 64'hffff_ffff_ffff_ffff;
			9: return 64'h0020_0000_0000_0001;
			10: return 64'h0010_0000_0000_0000;
			11: return 64'h4000_0000_0000_0000;
			12: return 64'hffff_ff00_0000_0000;
			13: return 64'h000f_ffff_ffff_ffff;
			14: return 64'hefff_ffff_ffff_ffff;
			15: return 64'h0000_0000_0000_0400;
			default: return random_word();
		endcase
	endfunction

	function automatic exec_req_t random_int_op();
		exec_req_t req;
		req.op   = exec_op_e'(5'($urandom_range(7, 0)));
		req.comb = combine_e'(2'($urandom_range(3, 0)));
		req.a    = random_word();
		req.b    = random_word();
		req.c    = random_word();
		req.tag  = '0;
		// Zero and equal operands exercise CMOVZ and CMPLT edges
		if ($urandom_range(3, 0) == 0) req.a = '0;
		if ($urandom_range(7, 0) == 0) req.b = req.a;
		return req;
	endfunction

	task automatic end_run();
		$display("Summary: %0d checks, %0d errors, %0d results", checks, errors, rsp_seen);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic report_stall(input string what);
		errors++;
		$display("Timeout: %s did not complete within %0d cycles", what, WAIT_LIMIT);
		end_run();
	endtask

	task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want,
			input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL at %0t: %s gave %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int n;
		@(negedge clk);
		aw_valid = 1'b1;
		aw.addr  = addr;
		w_valid  = 1'b1;
		w.data   = data;
		w.strb   = strb;
		n = 0;
		@(posedge clk);
		while (!(aw_ready && w_ready)) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("AXI4-Lite write address and data");
			@(posedge clk);
		end
		@(negedge clk);
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		b_ready  = 1'b1;
		n = 0;
		@(posedge clk);
		while (!b_valid) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("AXI4-Lite write response");
			@(posedge clk);
		end
		resp = b.resp;
		@(negedge clk);
		b_ready = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		ar_valid = 1'b1;
		ar.addr  = addr;
		n = 0;
		@(posedge clk);
		while (!ar_ready) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("AXI4-Lite read address");
			@(posedge clk);
		end
		@(negedge clk);
		ar_valid = 1'b0;
		r_ready  = 1'b1;
		n = 0;
		@(posedge clk);
		while (!r_valid) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("AXI4-Lite read data");
			@(posedge clk);
		end
		data = r.data;
		resp = r.resp;
		@(negedge clk);
		r_ready = 1'b0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] want,
			input string what);
		logic [31:0] data;
		logic [1:0]  resp;
		read_reg(addr, data, resp);
		check_value(data, want, what);
		check_value(resp, RESP_OKAY, {what, " response"});
	endtask

	// Every register against what the testbench has tracked so far
	task automatic check_all_regs(input string when);
		check_read(REG_CTRL, ctrl_value, {"CTRL ", when});
		check_read(REG_DEFAULT_LO, dflt_value[31:0], {"DEFAULT_LO ", when});
		check_read(REG_DEFAULT_HI, dflt_value[63:32], {"DEFAULT_HI ", when});
		check_read(REG_OP_COUNT, 32'(ops_done), {"OP_COUNT ", when});
		check_read(REG_BAD_COUNT, 32'(bad_done), {"BAD_COUNT ", when});
	endtask

	// Tags come from a running counter and the expectation is queued on transfer
	task automatic issue_op(input exec_req_t req);
		int n;
		req.tag = next_tag;
		next_tag++;
		@(negedge clk);
		op       = req;
		op_valid = 1'b1;
		n = 0;
		@(posedge clk);
		while (!op_ready) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("Op issue");
			@(posedge clk);
		end
		expect_q.push_back(exec_model(req, dflt_value));
	endtask

	task automatic release_op();
		@(negedge clk);
		op_valid = 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while (expect_q.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) report_stall(what);
		end
	endtask

	task automatic close_test(input int num, input string name, input int start_errors);
		$display("Test %0d %s finished with %0d errors", num, name, errors - start_errors);
	endtask

	// ====================
	// Response side
	// ====================

	// Random stalls come from a pattern filled once from the seeded generator
	always @(negedge clk) begin
		if (ready_random) begin
			rsp_ready = ready_pat[pat_idx];
			pat_idx   = (pat_idx + 1) % 1024;
		end else begin
			rsp_ready = 1'b1;
		end
	end

	// Every result transfer pops the oldest expectation
	always @(posedge clk) begin
		exec_rsp_t want;
		if (!rst && rsp_valid && rsp_ready) begin
			rsp_seen++;
			checks++;
			if (expect_q.size() == 0) begin
				errors++;
				$display("FAIL at %0t: result with tag %h arrived with nothing pending",
					$time, rsp.tag);
			end else begin
				want = expect_q.pop_front();
				ops_done++;
				if (want.bad) bad_done++;
				if (rsp.tag !== want.tag) begin
					errors++;
					$display("FAIL at %0t: tag %h, expected %h", $time, rsp.tag, want.tag);
				end
				if (rsp.value !== want.value) begin
					errors++;
					$display("FAIL at %0t: tag %h value %h, expected %h", $time, rsp.tag,
						rsp.value, want.value);
				end
				if (rsp.bad !== want.bad) begin
					errors++;
					$display("FAIL at %0t: tag %h bad flag %b, expected %b", $time, rsp.tag,
						rsp.bad, want.bad);
				end
			end
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		exec_req_t   req;
		logic [31:0] data;
		logic [1:0]  resp;
		int          n;
		int          first;
		op_valid = 1'b0;
		op       = '0;
		aw_valid = 1'b0;
		aw       = '0;
		w_valid  = 1'b0;
		w        = '0;
		b_ready  = 1'b0;
		ar_valid = 1'b0;
		ar       = '0;
		r_ready  = 1'b0;
		void'($urandom(32'h8f5d_5a09));
		for (int i = 0; i < 1024; i++) ready_pat[i] = ($urandom % 8) < 5;

		n = 0;
		@(posedge clk);
		while (rst) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("Reset release");
			@(posedge clk);
		end

		// Port stays closed until enable is written
		first = errors;
		repeat (5) begin
			@(posedge clk);
			check_value(op_ready, 1'b0, "op_ready before enable");
		end
		check_all_regs("after reset");
		write_reg(REG_CTRL, 32'd1, 4'hf, resp);
		check_value(resp, RESP_OKAY, "CTRL write response");
		ctrl_value = 32'd1;
		n = 0;
		@(posedge clk);
		while (!op_ready) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("op_ready after enable");
			@(posedge clk);
		end
		close_test(1, "reset and enable", first);

		first = errors;
		for (int i = 0; i < 300; i++) issue_op(random_int_op());
		release_op();
		wait_drain("Integer op results");
		close_test(2, "integer and logic ops", first);

		first = errors;
		for (int i = 0; i < 256; i++) begin
			req      = random_int_op();
			req.op   = exec_op_e'(5'(8 + i % 8));
			req.a    = special_operand(i / 8);
			req.b    = special_operand(int'($urandom_range(31, 0)));
			issue_op(req);
		end
		release_op();
		wait_drain("Float op results");
		close_test(3, "sign, class and conversion ops", first);

		first = errors;
		n = rsp_seen;
		ready_random = 1'b1;
		for (int i = 0; i < 200; i++) begin
			req    = random_int_op();
			req.op = exec_op_e'(5'($urandom_range(15, 0)));
			req.a  = special_operand(int'($urandom_range(31, 0)));
			issue_op(req);
		end
		release_op();
		wait_drain("Results under back-pressure");
		ready_random = 1'b0;
		check_value(rsp_seen - n, 200, "result count under back-pressure");
		close_test(4, "back-pressure stream", first);

		// High half goes in two strobed writes
		first = errors;
		write_reg(REG_DEFAULT_LO, 32'h1234_5678, 4'hf, resp);
		check_value(resp, RESP_OKAY, "DEFAULT_LO write response");
		write_reg(REG_DEFAULT_HI, 32'haaaa_bbbb, 4'b0011, resp);
		check_value(resp, RESP_OKAY, "DEFAULT_HI write response");
		write_reg(REG_DEFAULT_HI, 32'hcccc_0000, 4'b1100, resp);
		check_value(resp, RESP_OKAY, "DEFAULT_HI write response");
		dflt_value = 64'hcccc_bbbb_1234_5678;
		for (int i = 0; i < 32; i++) begin
			req    = random_int_op();
			req.op = exec_op_e'(5'(16 + i % 16));
			issue_op(req);
		end
		release_op();
		wait_drain("Undefined op results");
		check_all_regs("after undefined ops");
		close_test(5, "undefined ops and counters", first);

		first = errors;
		write_reg(8'h20, 32'hffff_ffff, 4'hf, resp);
		check_value(resp, RESP_SLVERR, "write to 0x20 response");
		read_reg(8'h20, data, resp);
		check_value(resp, RESP_SLVERR, "read from 0x20 response");
		write_reg(REG_OP_COUNT, 32'h0000_0000, 4'hf, resp);
		check_value(resp, RESP_SLVERR, "OP_COUNT write response");
		check_all_regs("after bad accesses");
		// Ops still in flight must finish after enable is cleared
		for (int i = 0; i < 5; i++) issue_op(random_int_op());
		release_op();
		write_reg(REG_CTRL, 32'd0, 4'hf, resp);
		check_value(resp, RESP_OKAY, "CTRL clear response");
		ctrl_value = 32'd0;
		n = 0;
		@(posedge clk);
		while (op_ready) begin
			n++;
			if (n > WAIT_LIMIT) report_stall("op_ready fall after disable");
			@(posedge clk);
		end
		wait_drain("Drain after disable");
		@(negedge clk);
		op       = random_int_op();
		op_valid = 1'b1;
		repeat (20) begin
			@(posedge clk);
			check_value(op_ready, 1'b0, "op_ready while disabled");
			check_value(rsp_valid, 1'b0, "rsp_valid while disabled");
		end
		release_op();
		check_all_regs("after disable");
		close_test(6, "error responses and disable", first);

		end_run();
	end

endmodule

// ==== tests/tb_clock.sv ====
/*
  Clock and reset source for the testbench, 40 ns period.
  Reset is high from time zero and drops on a falling edge.
*/
`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release on the falling edge so the DUT sees a clean synchronous deassert
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule
